// File: build.f
common/cpuTypesPkg.sv
logic/fetchUnit.sv
logic/controlDecode.sv
logic/registerFile.sv
logic/executeStage.sv
pipeline/pipelineReg.sv
logic/pipelineCore.sv
verification/pipelineReg_sva.sv
verification/coreTb.sv

// File: common/cpuTypesPkg.sv
package cpuTypesPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;

  typedef enum logic [2:0] {
    aluAdd,
    aluSub,
    aluAnd,
    aluOr,
    aluSlt,
    aluLui
  } aluOpT;

  // primary opcodes
  localparam logic [5:0] opRtype = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opBne   = 6'h05;
  localparam logic [5:0] opAddiu = 6'h09;
  localparam logic [5:0] opOri   = 6'h0D;
  localparam logic [5:0] opLui   = 6'h0F;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2B;
  localparam logic [5:0] opHalt  = 6'h3F;

  // r-type function codes
  localparam logic [5:0] fnAddu = 6'h21;
  localparam logic [5:0] fnSubu = 6'h23;
  localparam logic [5:0] fnAnd  = 6'h24;
  localparam logic [5:0] fnOr   = 6'h25;
  localparam logic [5:0] fnSlt  = 6'h2A;

  // stage records, all zero means bubble
  typedef struct packed {
    logic valid;
    wordT instr;
    wordT pc;
    wordT npc;
  } ifIdT;

  typedef struct packed {
    logic   valid;
    wordT   pc;
    wordT   npc;
    wordT   instr;
    wordT   rdat1;
    wordT   rdat2;
    wordT   imm;
    regIdxT rt;
    regIdxT rd;
    logic   regDst;
    logic   aluSrc;
    aluOpT  aluOp;
    logic   memWr;
    logic   memRd;
    logic   beq;
    logic   bne;
    logic   jump;
    logic   regWr;
    logic   memToReg;
    logic   halt;
  } idExT;

  typedef struct packed {
    logic   valid;
    wordT   aluOut;
    wordT   rdat2;
    regIdxT wrDest;
    logic   memWr;
    logic   memRd;
    logic   regWr;
    logic   memToReg;
    logic   halt;
  } exMemT;

  typedef struct packed {
    logic   valid;
    wordT   aluOut;
    wordT   dmemLoad;
    regIdxT wrDest;
    logic   regWr;
    logic   memToReg;
    logic   halt;
  } memWbT;

endpackage

// File: logic/controlDecode.sv
`timescale 1ns/10ps

module controlDecode (
  input  cpuTypesPkg::wordT   instr,
  output cpuTypesPkg::regIdxT rs,
  output cpuTypesPkg::regIdxT rt,
  output cpuTypesPkg::regIdxT rd,
  output cpuTypesPkg::wordT   imm,
  output logic                regDst,
  output logic                aluSrc,
  output logic                memWr,
  output logic                memRd,
  output logic                beq,
  output logic                bne,
  output logic                jump,
  output logic                regWr,
  output logic                memToReg,
  output logic                halt,
  output cpuTypesPkg::aluOpT  aluOp
);
  import cpuTypesPkg::*;

  logic [5:0]  opcode;
  logic [5:0]  funct;
  logic [15:0] imm16;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];
  assign imm16  = instr[15:0];
  assign rs     = instr[25:21];
  assign rt     = instr[20:16];
  assign rd     = instr[15:11];

  // ori zero-extends, lui moves to the upper half, the rest sign-extend
  always_comb begin
    case (opcode)
      opOri:   imm = {16'h0000, imm16};
      opLui:   imm = {imm16, 16'h0000};
      default: imm = {{16{imm16[15]}}, imm16};
    endcase
  end

  always_comb begin
    regDst   = 1'b0;
    aluSrc   = 1'b0;
    memWr    = 1'b0;
    memRd    = 1'b0;
    beq      = 1'b0;
    bne      = 1'b0;
    jump     = 1'b0;
    regWr    = 1'b0;
    memToReg = 1'b0;
    halt     = 1'b0;
    aluOp    = aluAdd;
    case (opcode)
      opRtype: begin
        regDst = 1'b1;
        regWr  = 1'b1;
        case (funct)
          fnAddu: aluOp = aluAdd;
          fnSubu: aluOp = aluSub;
          fnAnd:  aluOp = aluAnd;
          fnOr:   aluOp = aluOr;
          fnSlt:  aluOp = aluSlt;
          default: begin
            // unsupported funct behaves as a no-op
            regDst = 1'b0;
            regWr  = 1'b0;
          end
        endcase
      end
      opAddiu: begin
        aluSrc = 1'b1;
        regWr  = 1'b1;
      end
      opOri: begin
        aluSrc = 1'b1;
        regWr  = 1'b1;
        aluOp  = aluOr;
      end
      opLui: begin
        aluSrc = 1'b1;
        regWr  = 1'b1;
        aluOp  = aluLui;
      end
      opLw: begin
        aluSrc   = 1'b1;
        regWr    = 1'b1;
        memRd    = 1'b1;
        memToReg = 1'b1;
      end
      opSw: begin
        aluSrc = 1'b1;
        memWr  = 1'b1;
      end
      opBeq: begin
        beq   = 1'b1;
        aluOp = aluSub;
      end
      opBne: begin
        bne   = 1'b1;
        aluOp = aluSub;
      end
      opJ:     jump = 1'b1;
      opHalt:  halt = 1'b1;
      default: ;
    endcase
  end

endmodule

// File: logic/executeStage.sv
`timescale 1ns/10ps

module executeStage (
  input  cpuTypesPkg::idExT   idEx,
  output cpuTypesPkg::wordT   aluOut,
  output cpuTypesPkg::regIdxT wrDest,
  output logic                taken,
  output cpuTypesPkg::wordT   target
);
  import cpuTypesPkg::*;

  wordT opA;
  wordT opB;
  wordT branchOffset;
  wordT jumpAddr;
  logic zero;

  assign opA = idEx.rdat1;
  assign opB = idEx.aluSrc ? idEx.imm : idEx.rdat2;

  always_comb begin
    case (idEx.aluOp)
      aluAdd:  aluOut = opA + opB;
      aluSub:  aluOut = opA - opB;
      aluAnd:  aluOut = opA & opB;
      aluOr:   aluOut = opA | opB;
      aluSlt:  aluOut = ($signed(opA) < $signed(opB)) ? 32'd1 : 32'd0;
      // immediate already sits in the upper half
      aluLui:  aluOut = opB;
      default: aluOut = opA + opB;
    endcase
  end

  // branches subtract, so equal operands give zero
  assign zero = (aluOut == '0);

  assign taken = idEx.valid
               & ((idEx.beq & zero) | (idEx.bne & ~zero) | idEx.jump);

  assign branchOffset = {idEx.imm[29:0], 2'b00};
  assign jumpAddr     = {idEx.npc[31:28], idEx.instr[25:0], 2'b00};

  assign target = idEx.jump ? jumpAddr : idEx.npc + branchOffset;

  // rd for r-type, rt for immediates and loads
  assign wrDest = idEx.regDst ? idEx.rd : idEx.rt;

endmodule

// File: logic/fetchUnit.sv
`timescale 1ns/10ps

module fetchUnit #(
  parameter cpuTypesPkg::wordT resetPc = '0
) (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              advance,
  input  logic              redirect,
  input  cpuTypesPkg::wordT redirectTarget,
  output cpuTypesPkg::wordT pc,
  output cpuTypesPkg::wordT npc
);
  import cpuTypesPkg::*;

  wordT pcNext;

  // sequential address, also the base for branch targets
  assign npc = pc + 32'd4;

  always_comb begin
    if (redirect) begin
      pcNext = redirectTarget;
    end else begin
      pcNext = npc;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      pc <= resetPc;
    end else if (advance) begin
      pc <= pcNext;
    end
  end

endmodule

// File: logic/pipelineCore.sv
`timescale 1ns/10ps

module pipelineCore #(
  parameter cpuTypesPkg::wordT resetPc = '0
) (
  input  logic                CLK,
  input  logic                nRST,
  output cpuTypesPkg::wordT   imemAddr,
  output logic                imemRen,
  input  cpuTypesPkg::wordT   imemLoad,
  input  logic                ihit,
  output cpuTypesPkg::wordT   dmemAddr,
  output cpuTypesPkg::wordT   dmemStore,
  output logic                dmemRen,
  output logic                dmemWen,
  input  cpuTypesPkg::wordT   dmemLoad,
  input  logic                dhit,
  output logic                wbEn,
  output cpuTypesPkg::regIdxT wbSel,
  output cpuTypesPkg::wordT   wbData,
  output logic                halt
);
  import cpuTypesPkg::*;

  wordT   pc;
  wordT   npc;
  logic   advance;
  logic   memDone;
  logic   flush;
  logic   memPending;
  logic   haltSeen;
  ifIdT   ifId;
  idExT   idEx;
  exMemT  exMem;
  memWbT  memWb;
  idExT   decodeBundle;

  regIdxT rs;
  regIdxT rt;
  regIdxT rd;
  wordT   imm;
  logic   regDst;
  logic   aluSrc;
  logic   memWr;
  logic   memRd;
  logic   beq;
  logic   bne;
  logic   jump;
  logic   regWr;
  logic   memToReg;
  logic   haltDec;
  aluOpT  aluOp;
  wordT   rDat1;
  wordT   rDat2;

  wordT   aluOut;
  regIdxT wrDest;
  logic   taken;
  wordT   target;

  // sticky once a HALT has reached write-back
  assign halt = haltSeen | (memWb.valid & memWb.halt);

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      haltSeen <= 1'b0;
    end else if (memWb.valid && memWb.halt) begin
      haltSeen <= 1'b1;
    end
  end

  // younger work stranded in exMem after halt never reaches memory
  assign dmemRen    = exMem.valid & exMem.memRd & ~halt;
  assign dmemWen    = exMem.valid & exMem.memWr & ~halt;
  assign dmemAddr   = exMem.aluOut;
  assign dmemStore  = exMem.rdat2;
  assign memPending = dmemRen | dmemWen;

  assign advance = ihit & ~memPending & ~halt;
  assign memDone = dhit & memPending;
  assign flush   = advance & taken;

  assign imemAddr = pc;
  assign imemRen  = ~halt;

  assign wbEn   = memWb.valid & memWb.regWr & (memWb.wrDest != '0);
  assign wbSel  = memWb.wrDest;
  assign wbData = memWb.memToReg ? memWb.dmemLoad : memWb.aluOut;

  fetchUnit #(
    .resetPc(resetPc)
  ) fetch (
    .CLK           (CLK),
    .nRST          (nRST),
    .advance       (advance),
    .redirect      (taken),
    .redirectTarget(target),
    .pc            (pc),
    .npc           (npc)
  );

  controlDecode decode (
    .instr   (ifId.instr),
    .rs      (rs),
    .rt      (rt),
    .rd      (rd),
    .imm     (imm),
    .regDst  (regDst),
    .aluSrc  (aluSrc),
    .memWr   (memWr),
    .memRd   (memRd),
    .beq     (beq),
    .bne     (bne),
    .jump    (jump),
    .regWr   (regWr),
    .memToReg(memToReg),
    .halt    (haltDec),
    .aluOp   (aluOp)
  );

  registerFile regFile (
    .CLK  (CLK),
    .nRST (nRST),
    .wEn  (wbEn),
    .wSel (wbSel),
    .wDat (wbData),
    .rSel1(rs),
    .rSel2(rt),
    .rDat1(rDat1),
    .rDat2(rDat2)
  );

  // decode record headed for idEx
  always_comb begin
    decodeBundle          = '0;
    decodeBundle.valid    = ifId.valid;
    decodeBundle.pc       = ifId.pc;
    decodeBundle.npc      = ifId.npc;
    decodeBundle.instr    = ifId.instr;
    decodeBundle.rdat1    = rDat1;
    decodeBundle.rdat2    = rDat2;
    decodeBundle.imm      = imm;
    decodeBundle.rt       = rt;
    decodeBundle.rd       = rd;
    decodeBundle.regDst   = regDst;
    decodeBundle.aluSrc   = aluSrc;
    decodeBundle.aluOp    = aluOp;
    decodeBundle.memWr    = memWr;
    decodeBundle.memRd    = memRd;
    decodeBundle.beq      = beq;
    decodeBundle.bne      = bne;
    decodeBundle.jump     = jump;
    decodeBundle.regWr    = regWr;
    decodeBundle.memToReg = memToReg;
    decodeBundle.halt     = haltDec;
  end

  executeStage execute (
    .idEx  (idEx),
    .aluOut(aluOut),
    .wrDest(wrDest),
    .taken (taken),
    .target(target)
  );

  pipelineReg stageRegs (
    .CLK       (CLK),
    .nRST      (nRST),
    .advance   (advance),
    .memDone   (memDone),
    .flush     (flush),
    .inImemLoad(imemLoad),
    .inPc      (pc),
    .inNpc     (npc),
    .inDecode  (decodeBundle),
    .inAluOut  (aluOut),
    .inWrDest  (wrDest),
    .inDmemLoad(dmemLoad),
    .ifId      (ifId),
    .idEx      (idEx),
    .exMem     (exMem),
    .memWb     (memWb)
  );

endmodule

// File: logic/registerFile.sv
`timescale 1ns/10ps

module registerFile (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                wEn,
  input  cpuTypesPkg::regIdxT wSel,
  input  cpuTypesPkg::wordT   wDat,
  input  cpuTypesPkg::regIdxT rSel1,
  input  cpuTypesPkg::regIdxT rSel2,
  output cpuTypesPkg::wordT   rDat1,
  output cpuTypesPkg::wordT   rDat2
);
  import cpuTypesPkg::*;

  wordT regs [32];
  logic bypass1;
  logic bypass2;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wEn && wSel != '0) begin
      // $zero never takes a write
      regs[wSel] <= wDat;
    end
  end

  // same-cycle write is visible to decode
  assign bypass1 = wEn && (wSel == rSel1) && (rSel1 != '0);
  assign bypass2 = wEn && (wSel == rSel2) && (rSel2 != '0);

  assign rDat1 = bypass1 ? wDat : regs[rSel1];
  assign rDat2 = bypass2 ? wDat : regs[rSel2];

endmodule

// File: pipeline/pipelineReg.sv
`timescale 1ns/10ps

module pipelineReg (
  input  logic                CLK,
  input  logic                nRST,
  input  logic                advance,
  input  logic                memDone,
  input  logic                flush,
  input  cpuTypesPkg::wordT   inImemLoad,
  input  cpuTypesPkg::wordT   inPc,
  input  cpuTypesPkg::wordT   inNpc,
  input  cpuTypesPkg::idExT   inDecode,
  input  cpuTypesPkg::wordT   inAluOut,
  input  cpuTypesPkg::regIdxT inWrDest,
  input  cpuTypesPkg::wordT   inDmemLoad,
  output cpuTypesPkg::ifIdT   ifId,
  output cpuTypesPkg::idExT   idEx,
  output cpuTypesPkg::exMemT  exMem,
  output cpuTypesPkg::memWbT  memWb
);
  import cpuTypesPkg::*;

  ifIdT  nextIfId;
  idExT  nextIdEx;
  exMemT nextExMem;
  memWbT nextMemWb;

  // fetched word entering decode
  always_comb begin
    nextIfId       = '0;
    nextIfId.valid = 1'b1;
    nextIfId.instr = inImemLoad;
    nextIfId.pc    = inPc;
    nextIfId.npc   = inNpc;
  end

  // decode bundle only counts behind a real instruction
  always_comb begin
    nextIdEx = '0;
    if (inDecode.valid) begin
      nextIdEx = inDecode;
    end
  end

  // execute results plus the flags memory and write-back still need
  always_comb begin
    nextExMem = '0;
    if (idEx.valid) begin
      nextExMem.valid    = 1'b1;
      nextExMem.aluOut   = inAluOut;
      nextExMem.rdat2    = idEx.rdat2;
      nextExMem.wrDest   = inWrDest;
      nextExMem.memWr    = idEx.memWr;
      nextExMem.memRd    = idEx.memRd;
      nextExMem.regWr    = idEx.regWr;
      nextExMem.memToReg = idEx.memToReg;
      nextExMem.halt     = idEx.halt;
    end
  end

  // load data is sampled here, on the cycle the access completes
  always_comb begin
    nextMemWb = '0;
    if (exMem.valid) begin
      nextMemWb.valid    = 1'b1;
      nextMemWb.aluOut   = exMem.aluOut;
      nextMemWb.dmemLoad = inDmemLoad;
      nextMemWb.wrDest   = exMem.wrDest;
      nextMemWb.regWr    = exMem.regWr;
      nextMemWb.memToReg = exMem.memToReg;
      nextMemWb.halt     = exMem.halt;
    end
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifId  <= '0;
      idEx  <= '0;
      exMem <= '0;
      memWb <= '0;
    end else if (advance) begin
      // squash the two younger slots behind a taken branch
      if (flush) begin
        ifId <= '0;
        idEx <= '0;
      end else begin
        ifId <= nextIfId;
        idEx <= nextIdEx;
      end
      exMem <= nextExMem;
      memWb <= nextMemWb;
    end else if (memDone) begin
      // drain the finished access, front stages hold
      exMem <= '0;
      memWb <= nextMemWb;
    end else begin
      // hold everything, but never repeat a write-back
      memWb <= '0;
    end
  end

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module coreTb -o coreSim

out=$(./obj_dir/coreSim || true)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "All tests passed"

// File: verification/coreTb.sv
`timescale 1ns/10ps

module coreTb;
  import cpuTypesPkg::*;

  localparam int memWords = 256;

  logic   CLK;
  logic   nRST;
  wordT   imemAddr;
  logic   imemRen;
  wordT   imemLoad;
  logic   ihit;
  wordT   dmemAddr;
  wordT   dmemStore;
  logic   dmemRen;
  logic   dmemWen;
  wordT   dmemLoad;
  logic   dhit;
  logic   wbEn;
  regIdxT wbSel;
  wordT   wbData;
  logic   halt;

  wordT imem [memWords];
  wordT dmem [memWords];

  // expected write-backs and stores in program order
  wordT expWbSel [$];
  wordT expWbData [$];
  wordT expStAddr [$];
  wordT expStData [$];

  int          wbSeen;
  int          stSeen;
  int          wbErrors;
  int          stErrors;
  int          monErrors;
  int          endErrors;
  int          instrCount;
  logic        loaded;
  logic        stimOk;
  logic [15:0] lfsr;
  int          iWait;
  int          dWait;

  pipelineCore #(
    .resetPc(32'h0000_0000)
  ) dut (
    .CLK      (CLK),
    .nRST     (nRST),
    .imemAddr (imemAddr),
    .imemRen  (imemRen),
    .imemLoad (imemLoad),
    .ihit     (ihit),
    .dmemAddr (dmemAddr),
    .dmemStore(dmemStore),
    .dmemRen  (dmemRen),
    .dmemWen  (dmemWen),
    .dmemLoad (dmemLoad),
    .dhit     (dhit),
    .wbEn     (wbEn),
    .wbSel    (wbSel),
    .wbData   (wbData),
    .halt     (halt)
  );

  // combinational memories paced only by the hit levels
  assign imemLoad = imem[imemAddr[9:2]];
  // load data only appears behind the read strobe
  assign dmemLoad = dmemRen ? dmem[dmemAddr[9:2]] : 32'hBAD0_BAD0;

  initial begin
    CLK = 1'b0;
    forever begin
      #2 CLK = ~CLK;
    end
  end

  // one Galois step with maximal 16-bit taps
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // 0 to 3 withheld cycles from two LFSR bits
  task automatic drawWait(output int w);
    logic [1:0] bits;
    for (int b = 0; b < 2; b++) begin
      bits[b] = lfsr[0];
      lfsr    = lfsrNext(lfsr);
    end
    w = int'(bits);
  endtask

  task automatic readStim();
    int    fd;
    int    n;
    string line;
    byte   kind;
    wordT  a;
    wordT  v;
    fd = $fopen("verification/core_stim.txt", "r");
    stimOk = (fd != 0);
    while (stimOk && !$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        kind = line.getc(0);
        n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, v);
        if (n == 2) begin
          case (kind)
            "I": begin
              imem[a[9:2]] = v;
              instrCount++;
            end
            "D": dmem[a[9:2]] = v;
            "W": begin
              expWbSel.push_back(a);
              expWbData.push_back(v);
            end
            "S": begin
              expStAddr.push_back(a);
              expStData.push_back(v);
            end
            default: begin
              $display("unknown record kind in stimulus line: %s", line);
              monErrors++;
            end
          endcase
        end
      end
    end
    if (stimOk) begin
      $fclose(fd);
    end
  endtask

  task automatic expectLevel(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      monErrors++;
    end
  endtask

  task automatic checkWriteBack();
    if (halt) begin
      $display("write-back to register %0d after halt", wbSel);
      monErrors++;
    end else if (wbSeen >= expWbSel.size()) begin
      $display("extra write-back to register %0d beyond the expected list", wbSel);
      monErrors++;
    end else begin
      if ({27'd0, wbSel} != expWbSel[wbSeen]) begin
        $display("FAILED wbSel: got %h, expected %h (write-back %0d)",
                 wbSel, expWbSel[wbSeen], wbSeen);
        wbErrors++;
      end
      if (wbData != expWbData[wbSeen]) begin
        $display("FAILED wbData: got %h, expected %h (write-back %0d)",
                 wbData, expWbData[wbSeen], wbSeen);
        wbErrors++;
      end
      wbSeen++;
    end
  endtask

  task automatic checkStore();
    if (halt) begin
      $display("store to address %h after halt", dmemAddr);
      monErrors++;
    end else if (stSeen >= expStAddr.size()) begin
      $display("extra store to address %h beyond the expected list", dmemAddr);
      monErrors++;
    end else begin
      if (dmemAddr != expStAddr[stSeen]) begin
        $display("FAILED dmemAddr: got %h, expected %h (store %0d)",
                 dmemAddr, expStAddr[stSeen], stSeen);
        stErrors++;
      end
      if (dmemStore != expStData[stSeen]) begin
        $display("FAILED dmemStore: got %h, expected %h (store %0d)",
                 dmemStore, expStData[stSeen], stSeen);
        stErrors++;
      end
      stSeen++;
    end
    dmem[dmemAddr[9:2]] = dmemStore;
  endtask

  // load memories then sample on the falling edge
  initial begin
    loaded = 1'b0;
    for (int i = 0; i < memWords; i++) begin
      imem[i] = '0;
      dmem[i] = 32'hDEAD0000 ^ 32'(i << 2);
    end
    readStim();
    loaded = 1'b1;
    forever begin
      @(negedge CLK);
      if (nRST && wbEn) begin
        checkWriteBack();
      end
      if (nRST && dmemWen && dhit) begin
        checkStore();
      end
    end
  end

  // hit levels withheld for a random number of cycles
  initial begin
    ihit = 1'b0;
    dhit = 1'b0;
    lfsr = 16'd78;
    drawWait(iWait);
    drawWait(dWait);
    wait (nRST === 1'b1);
    forever begin
      @(posedge CLK);
      #1;
      if (iWait > 0) begin
        ihit  = 1'b0;
        iWait = iWait - 1;
      end else begin
        ihit = 1'b1;
        drawWait(iWait);
      end
      if (!(dmemRen || dmemWen)) begin
        dhit = 1'b0;
      end else if (dWait > 0) begin
        dhit  = 1'b0;
        dWait = dWait - 1;
      end else begin
        dhit = 1'b1;
        drawWait(dWait);
      end
    end
  end

  initial begin
    wait (loaded === 1'b1);
    repeat (40 * instrCount + 200) @(posedge CLK);
    $display("watchdog expired after %0d cycles without halt", 40 * instrCount + 200);
    $display("Some tests failed");
    $finish;
  end

  initial begin
    nRST = 1'b0;
    endErrors = 0;
    wait (loaded === 1'b1);
    if (!stimOk) begin
      $display("could not open verification/core_stim.txt");
      $display("Some tests failed");
      $finish;
    end else begin
      repeat (3) @(posedge CLK);
      #1;
      // fetch is requested in reset while the rest stays idle
      expectLevel("imemRen", imemRen, 1'b1);
      expectLevel("dmemRen", dmemRen, 1'b0);
      expectLevel("dmemWen", dmemWen, 1'b0);
      expectLevel("wbEn", wbEn, 1'b0);
      expectLevel("halt", halt, 1'b0);
      nRST = 1'b1;
      wait (halt === 1'b1);
      // a few more cycles to catch late writes
      repeat (10) @(negedge CLK);
      #1;
      expectLevel("halt", halt, 1'b1);
      expectLevel("imemRen", imemRen, 1'b0);
      if (wbSeen != expWbSel.size()) begin
        $display("write-back list ran short: %0d of %0d seen", wbSeen, expWbSel.size());
        endErrors++;
      end
      if (stSeen != expStAddr.size()) begin
        $display("store list ran short: %0d of %0d seen", stSeen, expStAddr.size());
        endErrors++;
      end
      $display("errors: %0d write-back, %0d store, %0d other",
               wbErrors, stErrors, monErrors + endErrors);
      if (wbErrors + stErrors + monErrors + endErrors == 0) begin
        $display("All tests passed");
      end else begin
        $display("Some tests failed");
      end
      $finish;
    end
  end

endmodule

// File: verification/core_stim.txt
# kind address-or-register value, both hex
# I program word, D initial data, W expected write-back, S expected store
I 00000000 3c011234
I 00000004 340200f0
I 00000008 2403fffd
I 0000000c 34215678
I 00000010 00422021
I 00000014 00622823
I 00000018 00223024
I 0000001c 00833825
I 00000020 00a2402a
I 00000024 0043482a
I 00000028 240c0110
I 0000002c 8c0a0100
I 00000030 8c0b0104
I 00000034 00c76821
I 00000038 ad8a0000
I 0000003c ad8b0004
I 00000040 11680003
I 00000044 240e0007
I 00000048 15600002
I 0000004c 240f0bad
I 00000050 240f0bad
I 00000054 11ce0002
I 00000058 240f0bad
I 0000005c 240f0bad
I 00000060 0800001c
I 00000064 240f0bad
I 00000068 240f0bad
I 00000070 15200004
I 00000074 8c100110
I 00000078 24110042
I 0000007c 00220021
I 00000080 ac100118
I 00000084 fc000000
I 00000088 240f0bad
D 00000100 cafef00d
D 00000104 00000005
W 00000001 12340000
W 00000002 000000f0
W 00000003 fffffffd
W 00000001 12345678
W 00000004 000001e0
W 00000005 ffffff0d
W 00000006 00000070
W 00000007 fffffffd
W 00000008 00000001
W 00000009 00000000
W 0000000c 00000110
W 0000000a cafef00d
W 0000000b 00000005
W 0000000d 0000006d
W 0000000e 00000007
W 00000010 cafef00d
W 00000011 00000042
S 00000110 cafef00d
S 00000114 00000005
S 00000118 cafef00d

// File: verification/pipelineReg_sva.sv
`timescale 1ns/10ps

module pipelineRegSva (
  input logic                CLK,
  input logic                nRST,
  input logic                advance,
  input logic                memDone,
  input logic                flush,
  input cpuTypesPkg::ifIdT   ifId,
  input cpuTypesPkg::idExT   idEx,
  input cpuTypesPkg::exMemT  exMem,
  input cpuTypesPkg::memWbT  memWb,
  input logic                wbEn,
  input logic                halt
);

  // stalled stages keep their records while write-back drains
  holdOnStall: assert property (
    @(posedge CLK) disable iff (!nRST)
    (!advance && !memDone) |=> (ifId == $past(ifId)) && (idEx == $past(idEx))
      && (exMem == $past(exMem)) && (memWb == '0)
  ) else $error("stage records changed during a stall");

  // two younger slots are squashed behind a taken branch
  squashOnFlush: assert property (
    @(posedge CLK) disable iff (!nRST)
    flush |=> (ifId == '0) && (idEx == '0)
  ) else $error("flush left a live entry in ifId or idEx");

  // a halted core commits nothing further
  noWriteAfterHalt: assert property (
    @(posedge CLK) disable iff (!nRST)
    halt |-> !wbEn
  ) else $error("register write while halted");

endmodule

bind pipelineCore pipelineRegSva stageChecks (
  .CLK    (CLK),
  .nRST   (nRST),
  .advance(advance),
  .memDone(memDone),
  .flush  (flush),
  .ifId   (ifId),
  .idEx   (idEx),
  .exMem  (exMem),
  .memWb  (memWb),
  .wbEn   (wbEn),
  .halt   (halt)
);
